// File: tb.f
logic/lsu_pkg.sv
logic/lsu_issue.sv
logic/store_align.sv
logic/load_align.sv
logic/read_fsm.sv
logic/write_fsm.sv
logic/lsu_top.sv
verif/lsu_assertions.sv
verif/lsu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := lsu_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

# static checks over the whole file list
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
	import lsu_pkg::*;

	localparam int RD_W = 5;
	localparam int NUM_OPS = 400;
	localparam int WAIT_LIMIT = 40;
	localparam word_t WIN_BASE = 32'h0000_1000;

	logic            clock;
	logic            reset;
	logic            in_valid;
	mem_op_t         in_op;
	word_t           in_base;
	word_t           in_offset;
	word_t           in_store_data;
	logic [RD_W-1:0] in_rd;
	logic            in_ready;
	logic            done;
	logic            rf_wen;
	logic [RD_W-1:0] rf_waddr;
	word_t           rf_wdata;
	logic            ar_valid;
	logic            ar_ready;
	word_t           ar_addr;
	logic            r_valid;
	logic            r_ready;
	beat_t           r_data;
	logic            aw_valid;
	logic            aw_ready;
	word_t           aw_addr;
	logic            w_valid;
	logic            w_ready;
	beat_t           w_data;
	strb_t           w_strb;
	logic            b_valid;
	logic            b_ready;

	logic [15:0] lfsr_state;
	// bus memory of 16 lines, byte model of the same 128 bytes
	beat_t       bus_mem [0:15];
	logic [7:0]  ref_mem [0:127];

	lsu_top #(
		.RF_ADDR_WIDTH(RD_W)
	) dut (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_base(in_base),
		.in_offset(in_offset),
		.in_store_data(in_store_data),
		.in_rd(in_rd),
		.in_ready(in_ready),
		.done(done),
		.rf_wen(rf_wen),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar_addr(ar_addr),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.r_data(r_data),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw_addr(aw_addr),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.w_data(w_data),
		.w_strb(w_strb),
		.b_valid(b_valid),
		.b_ready(b_ready)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] fill_byte(word_t a);
		return a[7:0] ^ {a[4:0], a[7:5]} ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
	endfunction

	function automatic logic [3:0] line_index(word_t a);
		return 4'((a - WIN_BASE) >> 3);
	endfunction

	task automatic abort_run(string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "stopping after the first failed check");
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_addr(string name, word_t got, word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_beat(string name, beat_t got, beat_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_strb(string name, strb_t got, strb_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	// an item is in flight, so the stage must stay closed
	task automatic check_pending();
		check_bit("in_ready", in_ready, 1'b0);
		check_bit("done", done, 1'b0);
	endtask

	task automatic read_access(word_t addr);
		int n;
		n = 0;
		while (!ar_valid) begin
			check_pending();
			check_bit("aw_valid", aw_valid, 1'b0);
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: ar_valid never came up for a load");
			end
			@(negedge clock);
		end
		check_addr("ar_addr", ar_addr, addr);
		repeat (int'(rand_bits(2))) @(negedge clock);
		ar_ready = 1'b1;
		@(negedge clock);
		ar_ready = 1'b0;
		n = 0;
		while (!r_ready) begin
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: r_ready never came up after the read address");
			end
			@(negedge clock);
		end
		repeat (int'(rand_bits(2))) begin
			check_pending();
			@(negedge clock);
			check_bit("r_ready", r_ready, 1'b1);
		end
		r_valid = 1'b1;
		r_data = bus_mem[line_index(addr)];
		@(negedge clock);
		r_valid = 1'b0;
		r_data = {rand_bits(32), rand_bits(32)};
	endtask

	task automatic write_access(word_t addr, beat_t exp_data, strb_t exp_strb);
		int n;
		n = 0;
		while (!aw_valid) begin
			check_pending();
			check_bit("ar_valid", ar_valid, 1'b0);
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: aw_valid never came up for a store");
			end
			@(negedge clock);
		end
		check_addr("aw_addr", aw_addr, addr);
		repeat (int'(rand_bits(2))) @(negedge clock);
		aw_ready = 1'b1;
		@(negedge clock);
		aw_ready = 1'b0;
		n = 0;
		while (!w_valid) begin
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: w_valid never came up after the write address");
			end
			@(negedge clock);
		end
		check_beat("w_data", w_data, exp_data);
		check_strb("w_strb", w_strb, exp_strb);
		repeat (int'(rand_bits(2))) @(negedge clock);
		w_ready = 1'b1;
		// memory takes only the strobed lanes
		for (int b = 0; b < 8; b++) begin
			if (w_strb[b]) begin
				bus_mem[line_index(addr)][b*8 +: 8] = w_data[b*8 +: 8];
			end
		end
		@(negedge clock);
		w_ready = 1'b0;
		n = 0;
		while (!b_ready) begin
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: b_ready never came up after the write data");
			end
			@(negedge clock);
		end
		repeat (int'(rand_bits(2))) @(negedge clock);
		b_valid = 1'b1;
		@(negedge clock);
		b_valid = 1'b0;
	endtask

	task automatic run_op(mem_op_t op, word_t base, word_t off, word_t data,
			logic [RD_W-1:0] rd);
		word_t       addr;
		word_t       line;
		word_t       expect_val;
		beat_t       lane_data;
		strb_t       strb_lo;
		strb_t       strb_hi;
		logic [31:0] r;
		logic        is_store;
		logic        crosses;
		int          lo;
		int          size;
		int          idx;
		int          n;

		addr = base + off;
		line = {addr[31:3], 3'b000};
		lo = int'(addr[2:0]);
		idx = int'(addr - WIN_BASE);
		case (op)
			op_lb, op_lbu, op_sb: size = 1;
			op_lh, op_lhu, op_sh: size = 2;
			default: size = 4;
		endcase
		is_store = (op == op_sb) || (op == op_sh) || (op == op_sw);
		crosses = (lo + size) > 8;

		// lanes and strobes worked out byte by byte
		strb_lo = '0;
		strb_hi = '0;
		for (int i = 0; i < size; i++) begin
			if (lo + i < 8) begin
				strb_lo[lo + i] = 1'b1;
			end else begin
				strb_hi[lo + i - 8] = 1'b1;
			end
		end
		for (int k = 0; k < 8; k++) begin
			lane_data[((k + lo) % 8)*8 +: 8] = (k < 4) ? data[k*8 +: 8] : 8'h00;
		end

		in_valid = 1'b1;
		in_op = op;
		in_base = base;
		in_offset = off;
		in_store_data = data;
		in_rd = rd;
		n = 0;
		while (!in_ready) begin
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: in_ready stayed low with an item offered");
			end
			@(negedge clock);
		end
		@(negedge clock);
		// the stage must work from its own copy
		r = rand_bits(8);
		in_valid = 1'b0;
		in_op = mem_op_t'(r[2:0]);
		in_rd = r[7:3];
		in_base = rand_bits(32);
		in_offset = rand_bits(32);
		in_store_data = rand_bits(32);

		if (is_store) begin
			write_access(line, lane_data, strb_lo);
			if (crosses) begin
				write_access(line + 32'd8, lane_data, strb_hi);
			end
			for (int i = 0; i < size; i++) begin
				ref_mem[idx + i] = data[i*8 +: 8];
			end
		end else begin
			read_access(line);
			if (crosses) begin
				read_access(line + 32'd8);
			end
		end

		n = 0;
		while (!done) begin
			check_bit("ar_valid", ar_valid, 1'b0);
			check_bit("aw_valid", aw_valid, 1'b0);
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: done never pulsed after the last bus access");
			end
			@(negedge clock);
		end
		check_bit("rf_wen", rf_wen, !is_store);
		if (!is_store) begin
			expect_val = '0;
			for (int i = 0; i < size; i++) begin
				expect_val[i*8 +: 8] = ref_mem[idx + i];
			end
			if (op == op_lb && expect_val[7]) begin
				expect_val[31:8] = '1;
			end
			if (op == op_lh && expect_val[15]) begin
				expect_val[31:16] = '1;
			end
			check_word("rf_wdata", rf_wdata, expect_val);
			check_word("rf_waddr", word_t'(rf_waddr), word_t'(rd));
		end
	endtask

	initial begin
		logic [31:0] r;
		mem_op_t     op;
		word_t       base;
		word_t       off;
		word_t       data;

		lfsr_state = 16'd4320;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = op_lb;
		in_base = '0;
		in_offset = '0;
		in_store_data = '0;
		in_rd = '0;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		for (int j = 0; j < 16; j++) begin
			for (int b = 0; b < 8; b++) begin
				bus_mem[j][b*8 +: 8] = fill_byte(WIN_BASE + word_t'(j*8 + b));
			end
		end
		for (int i = 0; i < 128; i++) begin
			ref_mem[i] = fill_byte(WIN_BASE + word_t'(i));
		end

		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_bit("in_ready", in_ready, 1'b1);
		check_bit("done", done, 1'b0);
		check_bit("rf_wen", rf_wen, 1'b0);
		check_bit("ar_valid", ar_valid, 1'b0);
		check_bit("r_ready", r_ready, 1'b0);
		check_bit("aw_valid", aw_valid, 1'b0);
		check_bit("w_valid", w_valid, 1'b0);
		check_bit("b_ready", b_ready, 1'b0);

		// sum of base and offset stays inside a 64 byte window
		for (int t = 0; t < NUM_OPS; t++) begin
			r = rand_bits(8);
			op = mem_op_t'(r[2:0]);
			base = WIN_BASE + rand_bits(5);
			off = rand_bits(5);
			data = rand_bits(32);
			run_op(op, base, off, data, r[7:3]);
		end

		@(negedge clock);
		check_bit("done", done, 1'b0);
		check_bit("in_ready", in_ready, 1'b1);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/lsu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
	input wire logic           clock,
	input wire logic           reset,
	input wire logic           done,
	input wire logic           ar_valid,
	input wire logic           ar_ready,
	input wire lsu_pkg::word_t ar_addr,
	input wire logic           aw_valid,
	input wire logic           aw_ready,
	input wire lsu_pkg::word_t aw_addr
);

	// requests stay up with a steady address until taken
	ar_held: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
		else $error("ar_valid dropped or ar_addr moved before ar_ready");

	aw_held: assert property (@(posedge clock) disable iff (reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
		else $error("aw_valid dropped or aw_addr moved before aw_ready");

	// only one access in flight
	one_request: assert property (@(posedge clock) disable iff (reset)
		!(ar_valid && aw_valid))
		else $error("ar_valid and aw_valid high together");

	// one item finishes with a single-cycle done
	done_one_cycle: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

endmodule

bind lsu_top lsu_assertions bus_checks (
	.clock(clock),
	.reset(reset),
	.done(done),
	.ar_valid(ar_valid),
	.ar_ready(ar_ready),
	.ar_addr(ar_addr),
	.aw_valid(aw_valid),
	.aw_ready(aw_ready),
	.aw_addr(aw_addr)
);

`default_nettype wire

// File: logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
	parameter int RF_ADDR_WIDTH = 5
) (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire logic                     in_valid,
	input  wire lsu_pkg::mem_op_t         in_op,
	input  wire lsu_pkg::word_t           in_base,
	input  wire lsu_pkg::word_t           in_offset,
	input  wire lsu_pkg::word_t           in_store_data,
	input  wire logic [RF_ADDR_WIDTH-1:0] in_rd,
	output logic                          in_ready,
	output logic                          done,
	output logic                          rf_wen,
	output logic [RF_ADDR_WIDTH-1:0]      rf_waddr,
	output lsu_pkg::word_t                rf_wdata,
	output logic                          ar_valid,
	input  wire logic                     ar_ready,
	output lsu_pkg::word_t                ar_addr,
	input  wire logic                     r_valid,
	output logic                          r_ready,
	input  wire lsu_pkg::beat_t           r_data,
	output logic                          aw_valid,
	input  wire logic                     aw_ready,
	output lsu_pkg::word_t                aw_addr,
	output logic                          w_valid,
	input  wire logic                     w_ready,
	output lsu_pkg::beat_t                w_data,
	output lsu_pkg::strb_t                w_strb,
	input  wire logic                     b_valid,
	output logic                          b_ready
);
	import lsu_pkg::*;

	mem_op_t   op;
	byte_off_t offset;
	word_t     line_addr;
	word_t     store_data;
	logic      split;
	logic      rd_start;
	logic      wr_start;
	logic      rd_done;
	logic      wr_done;
	logic      beat_fire;
	logic      rd_second;
	logic      wr_second;

	lsu_issue #(
		.RF_ADDR_WIDTH(RF_ADDR_WIDTH)
	) issue (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_base(in_base),
		.in_offset(in_offset),
		.in_store_data(in_store_data),
		.in_rd(in_rd),
		.rd_done(rd_done),
		.wr_done(wr_done),
		.in_ready(in_ready),
		.done(done),
		.rf_wen(rf_wen),
		.rf_waddr(rf_waddr),
		.op(op),
		.offset(offset),
		.line_addr(line_addr),
		.store_data(store_data),
		.rd_start(rd_start),
		.wr_start(wr_start),
		.split(split)
	);

	store_align st_align (
		.op(op),
		.offset(offset),
		.store_data(store_data),
		.second(wr_second),
		.w_data(w_data),
		.w_strb(w_strb)
	);

	load_align ld_align (
		.clock(clock),
		.reset(reset),
		.op(op),
		.offset(offset),
		.r_data(r_data),
		.beat_fire(beat_fire),
		.second(rd_second),
		.rf_wdata(rf_wdata)
	);

	read_fsm rd_fsm (
		.clock(clock),
		.reset(reset),
		.rd_start(rd_start),
		.split(split),
		.line_addr(line_addr),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.r_ready(r_ready),
		.beat_fire(beat_fire),
		.second(rd_second),
		.rd_done(rd_done)
	);

	write_fsm wr_fsm (
		.clock(clock),
		.reset(reset),
		.wr_start(wr_start),
		.split(split),
		.line_addr(line_addr),
		.aw_ready(aw_ready),
		.w_ready(w_ready),
		.b_valid(b_valid),
		.aw_valid(aw_valid),
		.aw_addr(aw_addr),
		.w_valid(w_valid),
		.b_ready(b_ready),
		.second(wr_second),
		.wr_done(wr_done)
	);

endmodule

`default_nettype wire

// File: logic/write_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module write_fsm (
	input  wire logic           clock,
	input  wire logic           reset,
	input  wire logic           wr_start,
	input  wire logic           split,
	input  wire lsu_pkg::word_t line_addr,
	input  wire logic           aw_ready,
	input  wire logic           w_ready,
	input  wire logic           b_valid,
	output logic                aw_valid,
	output lsu_pkg::word_t      aw_addr,
	output logic                w_valid,
	output logic                b_ready,
	output logic                second,
	output logic                wr_done
);
	import lsu_pkg::*;

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_addr = 3'd1;
	localparam logic [2:0] st_data = 3'd2;
	localparam logic [2:0] st_resp = 3'd3;
	localparam logic [2:0] st_fin  = 3'd4;

	logic [2:0] state;

	// address, data and response strictly in turn, one channel at a time
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			second <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (wr_start) begin
						state <= st_addr;
						second <= 1'b0;
					end
				end
				st_addr: begin
					if (aw_ready) begin
						state <= st_data;
					end
				end
				st_data: begin
					if (w_ready) begin
						state <= st_resp;
					end
				end
				st_resp: begin
					// second write goes to the following line
					if (b_valid) begin
						if (split && !second) begin
							second <= 1'b1;
							state <= st_addr;
						end else begin
							state <= st_fin;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign aw_valid = state == st_addr;
	assign w_valid = state == st_data;
	assign b_ready = state == st_resp;
	assign wr_done = state == st_fin;
	assign aw_addr = second ? line_addr + word_t'(BEAT_BYTES) : line_addr;

endmodule

`default_nettype wire

// File: logic/read_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module read_fsm (
	input  wire logic           clock,
	input  wire logic           reset,
	input  wire logic           rd_start,
	input  wire logic           split,
	input  wire lsu_pkg::word_t line_addr,
	input  wire logic           ar_ready,
	input  wire logic           r_valid,
	output logic                ar_valid,
	output lsu_pkg::word_t      ar_addr,
	output logic                r_ready,
	output logic                beat_fire,
	output logic                second,
	output logic                rd_done
);
	import lsu_pkg::*;

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_fin  = 2'd3;

	logic [1:0] state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			second <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (rd_start) begin
						state <= st_addr;
						second <= 1'b0;
					end
				end
				st_addr: begin
					if (ar_ready) begin
						state <= st_data;
					end
				end
				st_data: begin
					// crossing loads go round again for the next line
					if (r_valid) begin
						if (split && !second) begin
							second <= 1'b1;
							state <= st_addr;
						end else begin
							state <= st_fin;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign ar_valid = state == st_addr;
	assign r_ready = state == st_data;
	assign beat_fire = r_valid && r_ready;
	assign rd_done = state == st_fin;
	assign ar_addr = second ? line_addr + word_t'(BEAT_BYTES) : line_addr;

endmodule

`default_nettype wire

// File: logic/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire lsu_pkg::mem_op_t   op,
	input  wire lsu_pkg::byte_off_t offset,
	input  wire lsu_pkg::beat_t     r_data,
	input  wire logic               beat_fire,
	input  wire logic               second,
	output lsu_pkg::word_t          rf_wdata
);
	import lsu_pkg::*;

	beat_t                   first_beat;
	beat_t                   second_beat;
	logic [2*BEAT_WIDTH-1:0] pair_shifted;
	word_t                   raw;

	// hold both beats so the result is stable after the bus has moved on
	always_ff @(posedge clock) begin
		if (reset) begin
			first_beat <= '0;
			second_beat <= '0;
		end else if (beat_fire) begin
			if (second) begin
				second_beat <= r_data;
			end else begin
				first_beat <= r_data;
			end
		end
	end

	// second beat is stale on unsplit loads, its bytes never reach raw
	assign pair_shifted = {second_beat, first_beat} >> {offset, 3'b000};
	assign raw = pair_shifted[XLEN-1:0];

	always_comb begin
		case (op)
			op_lb: rf_wdata = {{24{raw[7]}}, raw[7:0]};
			op_lh: rf_wdata = {{16{raw[15]}}, raw[15:0]};
			op_lbu: rf_wdata = {24'd0, raw[7:0]};
			op_lhu: rf_wdata = {16'd0, raw[15:0]};
			default: rf_wdata = raw;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
	input  wire lsu_pkg::mem_op_t   op,
	input  wire lsu_pkg::byte_off_t offset,
	input  wire lsu_pkg::word_t     store_data,
	input  wire logic               second,
	output lsu_pkg::beat_t          w_data,
	output lsu_pkg::strb_t          w_strb
);
	import lsu_pkg::*;

	beat_t                     placed;
	logic [2*BEAT_WIDTH-1:0]   rot_pair;
	logic [3:0]                size_mask;
	logic [2*BEAT_BYTES-1:0]   strb_pair;

	// rotate left by offset bytes, so bytes past the line wrap to lane 0
	assign placed = beat_t'(store_data);
	assign rot_pair = {placed, placed} << {offset, 3'b000};
	assign w_data = rot_pair[2*BEAT_WIDTH-1:BEAT_WIDTH];

	always_comb begin
		case (op_size_bytes(op))
			3'd1: size_mask = 4'b0001;
			3'd2: size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	// low half covers the first line, high half the next one
	assign strb_pair = (2*BEAT_BYTES)'(size_mask) << offset;
	assign w_strb = second ? strb_pair[2*BEAT_BYTES-1:BEAT_BYTES] : strb_pair[BEAT_BYTES-1:0];

endmodule

`default_nettype wire

// File: logic/lsu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_issue #(
	parameter int RF_ADDR_WIDTH = 5
) (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire logic                     in_valid,
	input  wire lsu_pkg::mem_op_t         in_op,
	input  wire lsu_pkg::word_t           in_base,
	input  wire lsu_pkg::word_t           in_offset,
	input  wire lsu_pkg::word_t           in_store_data,
	input  wire logic [RF_ADDR_WIDTH-1:0] in_rd,
	input  wire logic                     rd_done,
	input  wire logic                     wr_done,
	output logic                          in_ready,
	output logic                          done,
	output logic                          rf_wen,
	output logic [RF_ADDR_WIDTH-1:0]      rf_waddr,
	output lsu_pkg::mem_op_t              op,
	output lsu_pkg::byte_off_t            offset,
	output lsu_pkg::word_t                line_addr,
	output lsu_pkg::word_t                store_data,
	output logic                          rd_start,
	output logic                          wr_start,
	output logic                          split
);
	import lsu_pkg::*;

	logic                     valid;
	logic                     accept;
	logic [RF_ADDR_WIDTH-1:0] rd;
	word_t                    addr_sum;
	logic [3:0]               end_byte;

	assign accept = in_valid && in_ready;
	assign addr_sum = in_base + in_offset;

	// one past the last byte touched, counted from the line start
	assign end_byte = {1'b0, addr_sum[2:0]} + {1'b0, op_size_bytes(in_op)};

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (in_ready) begin
			valid <= in_valid;
		end
	end

	// split decided here once, the machines only follow it
	always_ff @(posedge clock) begin
		if (accept) begin
			op <= in_op;
			line_addr <= {addr_sum[XLEN-1:3], 3'b000};
			offset <= addr_sum[2:0];
			split <= end_byte > 4'd8;
			store_data <= in_store_data;
			rd <= in_rd;
		end
	end

	assign rd_start = valid && op_is_load(op);
	assign wr_start = valid && op_is_store(op);

	// finishing machine frees the stage in the same cycle
	assign done = valid && (rd_done || wr_done);
	assign in_ready = !valid || done;

	assign rf_wen = done && op_is_load(op);
	assign rf_waddr = rd;

endmodule

`default_nettype wire

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	localparam int XLEN = 32;
	localparam int BEAT_WIDTH = 64;
	localparam int BEAT_BYTES = 8;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [BEAT_WIDTH-1:0] beat_t;
	typedef logic [BEAT_BYTES-1:0] strb_t;
	typedef logic [2:0] byte_off_t;

	// loads first, stores in the top three codes
	typedef enum logic [2:0] {
		op_lb  = 3'd0,
		op_lh  = 3'd1,
		op_lw  = 3'd2,
		op_lbu = 3'd3,
		op_lhu = 3'd4,
		op_sb  = 3'd5,
		op_sh  = 3'd6,
		op_sw  = 3'd7
	} mem_op_t;

	function automatic logic op_is_load(mem_op_t op);
		return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
	endfunction

	function automatic logic op_is_store(mem_op_t op);
		return op inside {op_sb, op_sh, op_sw};
	endfunction

	// access size in bytes: 1, 2 or 4
	function automatic logic [2:0] op_size_bytes(mem_op_t op);
		case (op)
			op_lb, op_lbu, op_sb: return 3'd1;
			op_lh, op_lhu, op_sh: return 3'd2;
			default: return 3'd4;
		endcase
	endfunction

endpackage

`default_nettype wire
